// File: source/riscv_pkg.sv
package riscv_pkg;

  //**************************************************
  // widths
  //**************************************************

  localparam int XLEN    = 32;
  localparam int REG_AW  = 5;
  localparam int ORDER_W = 64;
  localparam int INST_W  = 32;

  //**************************************************
  // operations
  //**************************************************

  // immediate forms share the register opcode, use_imm picks the operand
  typedef enum logic [4:0] {
    LUI,
    AUIPC,
    ADD,
    SUB,
    SLT,
    SLTU,
    XOR,
    OR,
    AND,
    SLL,
    SRL,
    SRA,
    JAL,
    JALR,
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU
  } op_e;

  //**************************************************
  // pipeline records
  //**************************************************

  // decoder output, imm already sign extended
  typedef struct packed {
    logic [INST_W-1:0]  inst;
    logic [ORDER_W-1:0] order;
    logic [XLEN-1:0]    pc;
    logic               br_taken;
    logic [XLEN-1:0]    pred_pc_next;
    op_e                op;
    logic               use_imm;
    logic [XLEN-1:0]    imm;
    logic [REG_AW-1:0]  rs1;
    logic [REG_AW-1:0]  rs2;
    logic [REG_AW-1:0]  rd;
  } decode_t;

  // dispatched instruction with its operands
  typedef struct packed {
    logic [INST_W-1:0]  inst;
    logic [ORDER_W-1:0] order;
    logic [XLEN-1:0]    pc;
    logic               br_taken;
    logic [XLEN-1:0]    pred_pc_next;
    op_e                op;
    logic               use_imm;
    logic [XLEN-1:0]    imm;
    logic [REG_AW-1:0]  rs1;
    logic [REG_AW-1:0]  rs2;
    logic [REG_AW-1:0]  rd;
    logic [XLEN-1:0]    rs1_data;
    logic [XLEN-1:0]    rs2_data;
  } issue_t;

  typedef struct packed {
    logic [INST_W-1:0]  inst;
    logic [ORDER_W-1:0] order;
    logic [XLEN-1:0]    pc;
    logic [XLEN-1:0]    pc_next;
    logic [REG_AW-1:0]  rs1;
    logic [REG_AW-1:0]  rs2;
    logic [XLEN-1:0]    rs1_data;
    logic [XLEN-1:0]    rs2_data;
    logic               rd_wr;
    logic [REG_AW-1:0]  rd;
    logic [XLEN-1:0]    rd_data;
    logic               br;
    logic               br_taken;
    logic               br_miss;
  } retire_t;

endpackage

// File: source/riscv_rfu.sv
`timescale 1ns/1ps

module riscv_rfu #(
  parameter int NUM_REGS = 32
) (
  input  logic                         clk,
  input  logic                         reset,

  input  logic [riscv_pkg::REG_AW-1:0] rd_addr_a,
  input  logic [riscv_pkg::REG_AW-1:0] rd_addr_b,
  output logic [riscv_pkg::XLEN-1:0]   rd_data_a,
  output logic [riscv_pkg::XLEN-1:0]   rd_data_b,

  input  logic                         wr_en,
  input  logic [riscv_pkg::REG_AW-1:0] wr_addr,
  input  logic [riscv_pkg::XLEN-1:0]   wr_data
);

  logic [riscv_pkg::XLEN-1:0] regs [NUM_REGS];

  // x0 is never written, so it stays at its reset value
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wr_en && wr_addr != '0 && wr_addr < NUM_REGS)
      regs[wr_addr] <= wr_data;
  end

  // indices past NUM_REGS read as zero (RV32E)
  assign rd_data_a = (rd_addr_a != '0 && rd_addr_a < NUM_REGS) ? regs[rd_addr_a] : '0;
  assign rd_data_b = (rd_addr_b != '0 && rd_addr_b < NUM_REGS) ? regs[rd_addr_b] : '0;

endmodule

// File: source/riscv_dpu.sv
`timescale 1ns/1ps

module riscv_dpu (
  input  logic                         clk,
  input  logic                         reset,

  input  logic                         idu_vld,
  input  riscv_pkg::decode_t           idu_decode,

  output logic [riscv_pkg::REG_AW-1:0] rf_addr_a,
  output logic [riscv_pkg::REG_AW-1:0] rf_addr_b,
  input  logic [riscv_pkg::XLEN-1:0]   rf_data_a,
  input  logic [riscv_pkg::XLEN-1:0]   rf_data_b,

  input  logic                         exu_vld,
  input  riscv_pkg::retire_t           exu_retire,

  output logic                         alu_issue_vld,
  output logic                         bru_issue_vld,
  output riscv_pkg::issue_t            dpu_issue
);

  riscv_pkg::decode_t         dec_q;
  logic                       dec_vld_q;
  logic                       squash;
  logic                       fwd_a;
  logic                       fwd_b;
  logic                       is_bru;
  logic [riscv_pkg::XLEN-1:0] rs1_data;
  logic [riscv_pkg::XLEN-1:0] rs2_data;

  // a retiring mispredicted branch kills the held and the incoming instruction
  assign squash = exu_vld & exu_retire.br_miss;

  always_ff @(posedge clk)
  begin
    if (reset)
      dec_vld_q <= 1'b0;
    else
      dec_vld_q <= idu_vld & ~squash;
  end

  always_ff @(posedge clk)
  begin
    if (idu_vld)
      dec_q <= idu_decode;
  end

  //**************************************************
  // operand read with forwarding
  //**************************************************

  assign rf_addr_a = dec_q.rs1;
  assign rf_addr_b = dec_q.rs2;

  assign fwd_a = exu_vld & exu_retire.rd_wr & (exu_retire.rd != '0) & (exu_retire.rd == dec_q.rs1);
  assign fwd_b = exu_vld & exu_retire.rd_wr & (exu_retire.rd != '0) & (exu_retire.rd == dec_q.rs2);

  assign rs1_data = fwd_a ? exu_retire.rd_data : rf_data_a;
  assign rs2_data = fwd_b ? exu_retire.rd_data : rf_data_b;

  //**************************************************
  // unit select
  //**************************************************

  assign is_bru = dec_q.op inside {riscv_pkg::JAL, riscv_pkg::JALR,
                                   riscv_pkg::BEQ, riscv_pkg::BNE,
                                   riscv_pkg::BLT, riscv_pkg::BGE,
                                   riscv_pkg::BLTU, riscv_pkg::BGEU};

  assign alu_issue_vld = dec_vld_q & ~squash & ~is_bru;
  assign bru_issue_vld = dec_vld_q & ~squash & is_bru;

  always_comb
  begin
    dpu_issue.inst         = dec_q.inst;
    dpu_issue.order        = dec_q.order;
    dpu_issue.pc           = dec_q.pc;
    dpu_issue.br_taken     = dec_q.br_taken;
    dpu_issue.pred_pc_next = dec_q.pred_pc_next;
    dpu_issue.op           = dec_q.op;
    dpu_issue.use_imm      = dec_q.use_imm;
    dpu_issue.imm          = dec_q.imm;
    dpu_issue.rs1          = dec_q.rs1;
    dpu_issue.rs2          = dec_q.rs2;
    dpu_issue.rd           = dec_q.rd;
    dpu_issue.rs1_data     = rs1_data;
    dpu_issue.rs2_data     = rs2_data;
  end

endmodule

// File: source/riscv_alu.sv
`timescale 1ns/1ps

module riscv_alu (
  input  logic               clk,
  input  logic               reset,

  input  logic               issue_vld,
  input  riscv_pkg::issue_t  issue,

  output logic               alu_vld,
  output riscv_pkg::retire_t alu_retire
);

  logic [riscv_pkg::XLEN-1:0] op_a;
  logic [riscv_pkg::XLEN-1:0] op_b;
  logic [4:0]                 shamt;
  logic [riscv_pkg::XLEN-1:0] result;
  riscv_pkg::retire_t         retire_d;

  assign op_a  = issue.rs1_data;
  assign op_b  = issue.use_imm ? issue.imm : issue.rs2_data;
  assign shamt = op_b[4:0];

  always_comb
  begin
    case (issue.op)
      riscv_pkg::LUI:   result = issue.imm;
      riscv_pkg::AUIPC: result = issue.pc + issue.imm;
      riscv_pkg::ADD:   result = op_a + op_b;
      riscv_pkg::SUB:   result = op_a - op_b;
      riscv_pkg::SLT:   result = {{(riscv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      riscv_pkg::SLTU:  result = {{(riscv_pkg::XLEN-1){1'b0}}, op_a < op_b};
      riscv_pkg::XOR:   result = op_a ^ op_b;
      riscv_pkg::OR:    result = op_a | op_b;
      riscv_pkg::AND:   result = op_a & op_b;
      riscv_pkg::SLL:   result = op_a << shamt;
      riscv_pkg::SRL:   result = op_a >> shamt;
      riscv_pkg::SRA:   result = $unsigned($signed(op_a) >>> shamt);
      default:          result = '0;
    endcase
  end

  always_comb
  begin
    retire_d.inst     = issue.inst;
    retire_d.order    = issue.order;
    retire_d.pc       = issue.pc;
    retire_d.pc_next  = issue.pc + 'd4;
    retire_d.rs1      = issue.rs1;
    retire_d.rs2      = issue.rs2;
    retire_d.rs1_data = issue.rs1_data;
    retire_d.rs2_data = issue.rs2_data;
    retire_d.rd_wr    = (issue.rd != '0);
    retire_d.rd       = issue.rd;
    retire_d.rd_data  = result;
    retire_d.br       = 1'b0;
    retire_d.br_taken = 1'b0;
    retire_d.br_miss  = 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      alu_vld <= 1'b0;
    else
      alu_vld <= issue_vld;
  end

  always_ff @(posedge clk)
  begin
    if (issue_vld)
      alu_retire <= retire_d;
  end

endmodule

// File: source/riscv_bru.sv
`timescale 1ns/1ps

module riscv_bru (
  input  logic               clk,
  input  logic               reset,

  input  logic               issue_vld,
  input  riscv_pkg::issue_t  issue,

  output logic               bru_vld,
  output riscv_pkg::retire_t bru_retire
);

  logic                       taken;
  logic                       is_jump;
  logic [riscv_pkg::XLEN-1:0] pc_seq;
  logic [riscv_pkg::XLEN-1:0] target;
  logic [riscv_pkg::XLEN-1:0] pc_next;
  riscv_pkg::retire_t         retire_d;

  assign is_jump = (issue.op == riscv_pkg::JAL) || (issue.op == riscv_pkg::JALR);
  assign pc_seq  = issue.pc + 'd4;

  always_comb
  begin
    case (issue.op)
      riscv_pkg::JAL,
      riscv_pkg::JALR: taken = 1'b1;
      riscv_pkg::BEQ:  taken = issue.rs1_data == issue.rs2_data;
      riscv_pkg::BNE:  taken = issue.rs1_data != issue.rs2_data;
      riscv_pkg::BLT:  taken = $signed(issue.rs1_data) < $signed(issue.rs2_data);
      riscv_pkg::BGE:  taken = $signed(issue.rs1_data) >= $signed(issue.rs2_data);
      riscv_pkg::BLTU: taken = issue.rs1_data < issue.rs2_data;
      riscv_pkg::BGEU: taken = issue.rs1_data >= issue.rs2_data;
      default:         taken = 1'b0;
    endcase
  end

  // jalr target drops bit 0
  assign target  = (issue.op == riscv_pkg::JALR) ?
                   ((issue.rs1_data + issue.imm) & ~riscv_pkg::XLEN'(1)) :
                   (issue.pc + issue.imm);
  assign pc_next = taken ? target : pc_seq;

  always_comb
  begin
    retire_d.inst     = issue.inst;
    retire_d.order    = issue.order;
    retire_d.pc       = issue.pc;
    retire_d.pc_next  = pc_next;
    retire_d.rs1      = issue.rs1;
    retire_d.rs2      = issue.rs2;
    retire_d.rs1_data = issue.rs1_data;
    retire_d.rs2_data = issue.rs2_data;
    retire_d.rd_wr    = is_jump && (issue.rd != '0);
    retire_d.rd       = issue.rd;
    retire_d.rd_data  = is_jump ? pc_seq : '0;
    retire_d.br       = 1'b1;
    retire_d.br_taken = taken;
    retire_d.br_miss  = (pc_next != issue.pred_pc_next);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      bru_vld <= 1'b0;
    else
      bru_vld <= issue_vld;
  end

  always_ff @(posedge clk)
  begin
    if (issue_vld)
      bru_retire <= retire_d;
  end

endmodule

// File: source/riscv_wbu.sv
`timescale 1ns/1ps

module riscv_wbu (
  input  logic                          alu_vld,
  input  riscv_pkg::retire_t            alu_retire,
  input  logic                          bru_vld,
  input  riscv_pkg::retire_t            bru_retire,

  output logic                          exu_vld,
  output riscv_pkg::retire_t            exu_retire,
  output logic [riscv_pkg::ORDER_W-1:0] exu_order_next,

  output logic                          wr_en,
  output logic [riscv_pkg::REG_AW-1:0]  wr_addr,
  output logic [riscv_pkg::XLEN-1:0]    wr_data
);

  // only one unit finishes per cycle
  assign exu_vld        = alu_vld | bru_vld;
  assign exu_retire     = bru_vld ? bru_retire : alu_retire;
  assign exu_order_next = exu_retire.order + 'd1;

  assign wr_en   = exu_vld & exu_retire.rd_wr;
  assign wr_addr = exu_retire.rd;
  assign wr_data = exu_retire.rd_data;

endmodule

// File: source/riscv_exu.sv
`timescale 1ns/1ps

module riscv_exu #(
  parameter int NUM_REGS = 32
) (
  input  logic                          clk,
  input  logic                          reset,

  input  logic                          idu_vld,
  input  riscv_pkg::decode_t            idu_decode,

  output logic                          exu_vld,
  output riscv_pkg::retire_t            exu_retire,
  output logic [riscv_pkg::ORDER_W-1:0] exu_order_next
);

  logic [riscv_pkg::REG_AW-1:0] rf_addr_a;
  logic [riscv_pkg::REG_AW-1:0] rf_addr_b;
  logic [riscv_pkg::XLEN-1:0]   rf_data_a;
  logic [riscv_pkg::XLEN-1:0]   rf_data_b;
  logic                         wr_en;
  logic [riscv_pkg::REG_AW-1:0] wr_addr;
  logic [riscv_pkg::XLEN-1:0]   wr_data;

  logic                         alu_issue_vld;
  logic                         bru_issue_vld;
  riscv_pkg::issue_t            dpu_issue;

  logic                         alu_vld;
  riscv_pkg::retire_t           alu_retire;
  logic                         bru_vld;
  riscv_pkg::retire_t           bru_retire;

  riscv_rfu #(
    .NUM_REGS (NUM_REGS)
  ) u_rfu (
    .clk       (clk),
    .reset     (reset),
    .rd_addr_a (rf_addr_a),
    .rd_addr_b (rf_addr_b),
    .rd_data_a (rf_data_a),
    .rd_data_b (rf_data_b),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  riscv_dpu u_dpu (
    .clk           (clk),
    .reset         (reset),
    .idu_vld       (idu_vld),
    .idu_decode    (idu_decode),
    .rf_addr_a     (rf_addr_a),
    .rf_addr_b     (rf_addr_b),
    .rf_data_a     (rf_data_a),
    .rf_data_b     (rf_data_b),
    .exu_vld       (exu_vld),
    .exu_retire    (exu_retire),
    .alu_issue_vld (alu_issue_vld),
    .bru_issue_vld (bru_issue_vld),
    .dpu_issue     (dpu_issue)
  );

  riscv_alu u_alu (
    .clk        (clk),
    .reset      (reset),
    .issue_vld  (alu_issue_vld),
    .issue      (dpu_issue),
    .alu_vld    (alu_vld),
    .alu_retire (alu_retire)
  );

  riscv_bru u_bru (
    .clk        (clk),
    .reset      (reset),
    .issue_vld  (bru_issue_vld),
    .issue      (dpu_issue),
    .bru_vld    (bru_vld),
    .bru_retire (bru_retire)
  );

  riscv_wbu u_wbu (
    .alu_vld        (alu_vld),
    .alu_retire     (alu_retire),
    .bru_vld        (bru_vld),
    .bru_retire     (bru_retire),
    .exu_vld        (exu_vld),
    .exu_retire     (exu_retire),
    .exu_order_next (exu_order_next),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data)
  );

endmodule

// File: verification/riscv_exu_vectors.svh
`ifndef RISCV_EXU_VECTORS_SVH
`define RISCV_EXU_VECTORS_SVH

// each row holds op, use_imm, imm, rs1, rs2, rd, miss, rnd and retire
// miss feeds the opposite prediction
// rnd replaces imm with an xorshift value
task automatic load_table();
  // preamble of known register values
  add_vec(riscv_pkg::ADD,   1, 32'h0000_0005,  0,  0,  1, 0, 0, 1);
  add_vec(riscv_pkg::ADD,   1, 32'hffff_fffd,  0,  0,  2, 0, 0, 1);
  add_vec(riscv_pkg::ADD,   1, 32'h0000_07ff,  0,  0,  3, 0, 0, 1);
  add_vec(riscv_pkg::ADD,   1, 32'hffff_f800,  0,  0,  4, 0, 0, 1);
  add_vec(riscv_pkg::ADD,   1, 32'h0000_0001,  0,  0,  5, 0, 0, 1);
  // register forms
  add_vec(riscv_pkg::ADD,   0, 32'h0000_0000,  1,  2,  6, 0, 0, 1);
  add_vec(riscv_pkg::SUB,   0, 32'h0000_0000,  1,  2,  7, 0, 0, 1);
  add_vec(riscv_pkg::SLT,   0, 32'h0000_0000,  2,  1,  8, 0, 0, 1);
  add_vec(riscv_pkg::SLTU,  0, 32'h0000_0000,  2,  1,  9, 0, 0, 1);
  add_vec(riscv_pkg::XOR,   0, 32'h0000_0000,  3,  4, 10, 0, 0, 1);
  add_vec(riscv_pkg::OR,    0, 32'h0000_0000,  1,  4, 11, 0, 0, 1);
  add_vec(riscv_pkg::AND,   0, 32'h0000_0000,  2,  3, 12, 0, 0, 1);
  add_vec(riscv_pkg::SLL,   0, 32'h0000_0000,  1,  5, 13, 0, 0, 1);
  add_vec(riscv_pkg::SRL,   0, 32'h0000_0000,  2,  1, 14, 0, 0, 1);
  add_vec(riscv_pkg::SRA,   0, 32'h0000_0000,  2,  1, 15, 0, 0, 1);
  // immediate forms
  add_vec(riscv_pkg::SLT,   1, 32'hffff_ffff,  2,  0, 16, 0, 0, 1);
  add_vec(riscv_pkg::SLTU,  1, 32'hffff_ffff,  1,  0, 17, 0, 0, 1);
  add_vec(riscv_pkg::XOR,   1, 32'hffff_ffff,  1,  0, 18, 0, 0, 1);
  add_vec(riscv_pkg::OR,    1, 32'h0000_00f0,  4,  0, 19, 0, 0, 1);
  add_vec(riscv_pkg::AND,   1, 32'h0000_07f0,  2,  0, 20, 0, 0, 1);
  add_vec(riscv_pkg::SLL,   1, 32'h0000_0014,  3,  0, 21, 0, 0, 1);
  add_vec(riscv_pkg::SRL,   1, 32'h0000_0008,  4,  0, 22, 0, 0, 1);
  add_vec(riscv_pkg::SRA,   1, 32'h0000_0008,  4,  0, 23, 0, 0, 1);
  add_vec(riscv_pkg::LUI,   1, 32'h1234_5000,  0,  0, 24, 0, 0, 1);
  add_vec(riscv_pkg::AUIPC, 1, 32'h0000_1000,  0,  0, 25, 0, 0, 1);
  // x0 ignores the write
  add_vec(riscv_pkg::ADD,   1, 32'h0000_0007,  1,  0,  0, 0, 0, 1);
  add_vec(riscv_pkg::ADD,   0, 32'h0000_0000,  0,  1, 26, 0, 0, 1);
  // dependent chain through forwarding
  add_vec(riscv_pkg::ADD,   1, 32'h0000_0001,  0,  0, 27, 0, 0, 1);
  add_vec(riscv_pkg::ADD,   1, 32'h0000_0002, 27,  0, 27, 0, 0, 1);
  add_vec(riscv_pkg::ADD,   1, 32'h0000_0003, 27,  0, 27, 0, 0, 1);
  add_vec(riscv_pkg::ADD,   0, 32'h0000_0000, 27, 27, 28, 0, 0, 1);
  // correctly predicted branches and jumps
  add_vec(riscv_pkg::BEQ,   0, 32'h0000_0010,  1,  1,  0, 0, 0, 1);
  add_vec(riscv_pkg::BNE,   0, 32'h0000_0010,  1,  1,  0, 0, 0, 1);
  add_vec(riscv_pkg::BNE,   0, 32'h0000_0018,  1,  2,  0, 0, 0, 1);
  add_vec(riscv_pkg::BLT,   0, 32'h0000_000c,  2,  1,  0, 0, 0, 1);
  add_vec(riscv_pkg::BLTU,  0, 32'h0000_000c,  2,  1,  0, 0, 0, 1);
  add_vec(riscv_pkg::BLTU,  0, 32'h0000_0014,  1,  2,  0, 0, 0, 1);
  add_vec(riscv_pkg::BGE,   0, 32'h0000_0020,  1,  2,  0, 0, 0, 1);
  add_vec(riscv_pkg::BGE,   0, 32'h0000_0020,  2,  1,  0, 0, 0, 1);
  add_vec(riscv_pkg::BGEU,  0, 32'h0000_0020,  2,  1,  0, 0, 0, 1);
  add_vec(riscv_pkg::BGEU,  0, 32'h0000_0020,  1,  2,  0, 0, 0, 1);
  add_vec(riscv_pkg::BLT,   0, 32'hffff_fff8,  1,  2,  0, 0, 0, 1);
  add_vec(riscv_pkg::JAL,   0, 32'h0000_0040,  0,  0, 29, 0, 0, 1);
  add_vec(riscv_pkg::JALR,  1, 32'h0000_0100,  1,  0, 30, 0, 0, 1);
  // the two rows after a mispredicted branch are squashed
  add_vec(riscv_pkg::BEQ,   0, 32'h0000_0010,  1,  2,  0, 1, 0, 1);
  add_vec(riscv_pkg::ADD,   1, 32'h0000_0064,  5,  0,  5, 0, 0, 0);
  add_vec(riscv_pkg::ADD,   1, 32'h0000_0001,  1,  0,  1, 0, 0, 0);
  add_vec(riscv_pkg::ADD,   0, 32'h0000_0000,  5,  1, 26, 0, 0, 1);
  // mispredicted jump
  add_vec(riscv_pkg::JAL,   0, 32'h0000_0020,  0,  0, 31, 1, 0, 1);
  add_vec(riscv_pkg::ADD,   1, 32'h0000_0001, 26,  0, 26, 0, 0, 0);
  add_vec(riscv_pkg::BNE,   0, 32'h0000_0010,  1,  2,  0, 1, 0, 0);
  add_vec(riscv_pkg::ADD,   0, 32'h0000_0000, 31,  0,  6, 0, 0, 1);
  // random tail
  add_vec(riscv_pkg::ADD,   1, 32'h0000_0000,  1,  0,  7, 0, 1, 1);
  add_vec(riscv_pkg::XOR,   1, 32'h0000_0000,  7,  0,  8, 0, 1, 1);
  add_vec(riscv_pkg::SLT,   1, 32'h0000_0000,  8,  0,  9, 0, 1, 1);
  add_vec(riscv_pkg::SLTU,  1, 32'h0000_0000,  7,  0, 10, 0, 1, 1);
  add_vec(riscv_pkg::OR,    1, 32'h0000_0000,  8,  0, 11, 0, 1, 1);
  add_vec(riscv_pkg::AND,   1, 32'h0000_0000, 11,  0, 12, 0, 1, 1);
  add_vec(riscv_pkg::SRA,   1, 32'h0000_0000,  4,  0, 13, 0, 1, 1);
  add_vec(riscv_pkg::ADD,   1, 32'h0000_0000, 13,  0, 14, 0, 1, 1);
endtask

`endif

// File: verification/riscv_exu_tb.sv
`timescale 1ns/1ps

module riscv_exu_tb;

  localparam int NUM_REGS    = 32;
  localparam int DRAIN_LIMIT = 100;

  // table row without order, pc and prediction
  typedef struct packed {
    riscv_pkg::op_e              op;
    logic                        use_imm;
    logic [riscv_pkg::XLEN-1:0]  imm;
    logic [riscv_pkg::REG_AW-1:0] rs1;
    logic [riscv_pkg::REG_AW-1:0] rs2;
    logic [riscv_pkg::REG_AW-1:0] rd;
    logic                        miss;
    logic                        rnd;
    logic                        retire;
  } vec_t;

  logic                          clk = 1'b0;
  logic                          reset;
  logic                          idu_vld;
  riscv_pkg::decode_t            idu_decode;
  logic                          exu_vld;
  riscv_pkg::retire_t            exu_retire;
  logic [riscv_pkg::ORDER_W-1:0] exu_order_next;

  vec_t                          vecs[$];
  riscv_pkg::retire_t            exp_q[$];
  int                            due_q[$];
  logic [riscv_pkg::XLEN-1:0]    model_regs [32];
  int                            cycle  = 0;
  int                            errors = 0;
  int                            checks = 0;

  vec_t                          v;
  riscv_pkg::decode_t            d;
  riscv_pkg::retire_t            e;
  riscv_pkg::retire_t            mon_exp;
  int                            mon_due;
  logic [riscv_pkg::XLEN-1:0]    tgt;
  logic [riscv_pkg::XLEN-1:0]    pc_model;
  logic [riscv_pkg::XLEN-1:0]    resume_pc;
  logic [riscv_pkg::ORDER_W-1:0] order_model;
  logic [riscv_pkg::ORDER_W-1:0] resume_order;
  logic [31:0]                   rng;
  int                            skip;
  int                            wait_cnt;

  riscv_exu #(
    .NUM_REGS (NUM_REGS)
  ) u_riscv_exu (
    .clk            (clk),
    .reset          (reset),
    .idu_vld        (idu_vld),
    .idu_decode     (idu_decode),
    .exu_vld        (exu_vld),
    .exu_retire     (exu_retire),
    .exu_order_next (exu_order_next)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  //**************************************************
  // helpers and reference model
  //**************************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_vec(input riscv_pkg::op_e op, input logic use_imm, input logic [31:0] imm,
                         input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
                         input logic miss, input logic rnd, input logic retire);
    vec_t row;
    row.op      = op;
    row.use_imm = use_imm;
    row.imm     = imm;
    row.rs1     = rs1;
    row.rs2     = rs2;
    row.rd      = rd;
    row.miss    = miss;
    row.rnd     = rnd;
    row.retire  = retire;
    vecs.push_back(row);
  endtask

  `include "riscv_exu_vectors.svh"

  // expected record from the model registers without br_miss
  function automatic riscv_pkg::retire_t expect_retire(input riscv_pkg::decode_t dec,
                                                       output logic [31:0] target);
    logic [31:0]        a;
    logic [31:0]        s;
    logic [31:0]        b;
    logic [31:0]        r;
    logic               cond;
    logic               jump;
    riscv_pkg::retire_t exp;
    a    = model_regs[dec.rs1];
    s    = model_regs[dec.rs2];
    b    = dec.use_imm ? dec.imm : s;
    r    = '0;
    cond = 1'b1;
    jump = (dec.op == riscv_pkg::JAL) || (dec.op == riscv_pkg::JALR);
    target = (dec.op == riscv_pkg::JALR) ? ((a + dec.imm) & 32'hffff_fffe) : (dec.pc + dec.imm);
    case (dec.op)
      riscv_pkg::LUI:   r = dec.imm;
      riscv_pkg::AUIPC: r = dec.pc + dec.imm;
      riscv_pkg::ADD:   r = a + b;
      riscv_pkg::SUB:   r = a - b;
      riscv_pkg::SLT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      riscv_pkg::SLTU:  r = (a < b) ? 32'd1 : 32'd0;
      riscv_pkg::XOR:   r = a ^ b;
      riscv_pkg::OR:    r = a | b;
      riscv_pkg::AND:   r = a & b;
      riscv_pkg::SLL:   r = a << b[4:0];
      riscv_pkg::SRL:   r = a >> b[4:0];
      riscv_pkg::SRA:   r = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
      riscv_pkg::BEQ:   cond = (a == s);
      riscv_pkg::BNE:   cond = (a != s);
      riscv_pkg::BLT:   cond = ($signed(a) < $signed(s));
      riscv_pkg::BGE:   cond = ($signed(a) >= $signed(s));
      riscv_pkg::BLTU:  cond = (a < s);
      riscv_pkg::BGEU:  cond = (a >= s);
      default:          r = dec.pc + 32'd4;
    endcase
    exp          = '0;
    exp.inst     = dec.inst;
    exp.order    = dec.order;
    exp.pc       = dec.pc;
    exp.rs1      = dec.rs1;
    exp.rs2      = dec.rs2;
    exp.rs1_data = a;
    exp.rs2_data = s;
    exp.rd       = dec.rd;
    exp.rd_data  = r;
    exp.br       = jump || (dec.op inside {riscv_pkg::BEQ, riscv_pkg::BNE, riscv_pkg::BLT,
                                           riscv_pkg::BGE, riscv_pkg::BLTU, riscv_pkg::BGEU});
    exp.br_taken = exp.br && cond;
    exp.pc_next  = exp.br_taken ? target : dec.pc + 32'd4;
    exp.rd_wr    = (dec.rd != '0) && (!exp.br || jump);
    return exp;
  endfunction

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("Fail %s got %0h expected %0h", name, got, exp);
    end
  endtask

  //**************************************************
  // monitor
  //**************************************************

  always @(negedge clk)
  begin
    if (reset)
    begin
      if (exu_vld !== 1'b0)
      begin
        errors++;
        $display("exu_vld is not low during reset at cycle %0d", cycle);
      end
    end
    else if (exu_vld === 1'b1)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("unexpected retire of order %0d at cycle %0d", exu_retire.order, cycle);
      end
      else
      begin
        mon_exp = exp_q.pop_front();
        mon_due = due_q.pop_front();
        checks++;
        if (cycle != mon_due)
        begin
          errors++;
          $display("order %0d retired at cycle %0d instead of %0d", mon_exp.order, cycle, mon_due);
        end
        check_field("exu_retire.order", exu_retire.order, mon_exp.order);
        check_field("exu_retire.pc", exu_retire.pc, mon_exp.pc);
        check_field("exu_retire.pc_next", exu_retire.pc_next, mon_exp.pc_next);
        check_field("exu_retire.rd_wr", exu_retire.rd_wr, mon_exp.rd_wr);
        check_field("exu_retire.rd_data", exu_retire.rd_data, mon_exp.rd_data);
        check_field("exu_retire.br_taken", exu_retire.br_taken, mon_exp.br_taken);
        check_field("exu_retire.br_miss", exu_retire.br_miss, mon_exp.br_miss);
        check_field("exu_order_next", exu_order_next, mon_exp.order + 64'd1);
        if (exu_retire !== mon_exp)
        begin
          errors++;
          $display("Fail exu_retire got %h expected %h", exu_retire, mon_exp);
        end
      end
    end
    else if (exu_vld !== 1'b0)
    begin
      errors++;
      $display("exu_vld is unknown at cycle %0d", cycle);
    end
  end

  //**************************************************
  // driver
  //**************************************************

  initial
  begin
    reset       = 1'b1;
    idu_vld     = 1'b0;
    idu_decode  = '0;
    rng         = 32'h4103_8823;
    pc_model    = 32'h0000_1000;
    order_model = '0;
    skip        = 0;
    for (int r = 0; r < 32; r++)
      model_regs[r] = '0;
    load_table();

    repeat (8) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < vecs.size(); i++)
    begin
      @(posedge clk);
      v = vecs[i];
      if (v.rnd)
      begin
        rng   = xorshift32(rng);
        v.imm = {{20{rng[11]}}, rng[11:0]};
      end
      d         = '0;
      d.inst    = 32'(i);
      d.order   = order_model;
      d.pc      = pc_model;
      d.op      = v.op;
      d.use_imm = v.use_imm;
      d.imm     = v.imm;
      d.rs1     = v.rs1;
      d.rs2     = v.rs2;
      d.rd      = v.rd;
      e = expect_retire(d, tgt);
      // a miss row predicts the opposite direction
      d.br_taken     = e.br && (v.miss ? !e.br_taken : e.br_taken);
      d.pred_pc_next = d.br_taken ? tgt : d.pc + 32'd4;
      e.br_miss      = e.br && (e.pc_next != d.pred_pc_next);
      if (v.retire != (skip == 0))
      begin
        errors++;
        $display("table row %0d retire flag disagrees with the squash rule", i);
      end
      idu_vld    <= 1'b1;
      idu_decode <= d;

      order_model = d.order + 64'd1;
      pc_model    = d.pred_pc_next;
      if (skip == 0)
      begin
        // cycle still holds the count before this edge
        exp_q.push_back(e);
        due_q.push_back(cycle + 3);
        if (e.rd_wr)
          model_regs[d.rd] = e.rd_data;
        if (e.br_miss)
        begin
          skip         = 2;
          resume_pc    = e.pc_next;
          resume_order = d.order + 64'd1;
        end
      end
      else
      begin
        skip--;
        if (skip == 0)
        begin
          order_model = resume_order;
          pc_model    = resume_pc;
        end
      end
    end

    @(posedge clk);
    idu_vld <= 1'b0;

    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT)
    begin
      @(posedge clk);
      wait_cnt++;
    end
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("timeout: %0d expected retires never appeared", exp_q.size());
    end
    // room for a stray retire to show up
    repeat (4) @(posedge clk);

    $display("retires checked %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// File: all.f
+incdir+verification
source/riscv_pkg.sv
source/riscv_rfu.sv
source/riscv_dpu.sv
source/riscv_alu.sv
source/riscv_bru.sv
source/riscv_wbu.sv
source/riscv_exu.sv
verification/riscv_exu_tb.sv

// File: Bender.yml
package:
  name: riscv_exu

sources:
  - source/riscv_pkg.sv
  - source/riscv_rfu.sv
  - source/riscv_dpu.sv
  - source/riscv_alu.sv
  - source/riscv_bru.sv
  - source/riscv_wbu.sv
  - source/riscv_exu.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/riscv_exu_tb.sv
